//--- common/lc3b_consts.svh
`ifndef LC3B_CONSTS_SVH
`define LC3B_CONSTS_SVH

// PC after reset.
`define LC3B_RESET_PC 16'h0000

// Cycles from grant to memory acknowledge.
`define LC3B_MEM_LATENCY 3

// Stored line-address bits and the resulting number of lines.
`define LC3B_MEM_LINE_BITS 6
`define LC3B_MEM_DEPTH (1 << `LC3B_MEM_LINE_BITS)

`endif

//--- common/lc3b_types.sv
package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [7:0]  lc3b_byte;

    // Next-PC source.
    typedef enum logic [1:0] {
        PC_PLUS2,
        PC_ALU,
        PC_PCN,
        PC_MDR
    } lc3b_pc_mux_sel;

    // Data-port operation.
    typedef enum logic [2:0] {
        MEM_NONE,
        MEM_LDR,
        MEM_STR,
        MEM_LDB,
        MEM_STB
    } lc3b_mem_op;

endpackage : lc3b_types

//--- common/lc3b_bus_pkg.sv
package lc3b_bus_pkg;

    // One line holds eight 16-bit words.
    typedef logic [127:0] lc3b_line;

    // Address bits 15 to 4.
    typedef logic [11:0] lc3b_line_addr;

    // One write enable per byte lane.
    typedef logic [15:0] lc3b_byte_sel;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_FETCH,
        ARB_DATA
    } lc3b_arb_state;

endpackage : lc3b_bus_pkg

//--- hw/fetch/stage_if.sv
`timescale 1ns/10ps
`include "lc3b_consts.svh"

module stage_if (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_stall,
    input  lc3b_types::lc3b_pc_mux_sel  i_pc_mux_sel,
    input  lc3b_types::lc3b_word        i_alu,
    input  lc3b_types::lc3b_word        i_pcn,
    input  lc3b_types::lc3b_word        i_mdr,
    input  logic                        i_ack,
    input  lc3b_bus_pkg::lc3b_line      i_rdata,

    output logic                        o_req,
    output lc3b_bus_pkg::lc3b_line_addr o_addr,
    output lc3b_types::lc3b_word        o_ir,
    output lc3b_types::lc3b_word        o_pc_plus2,
    output logic                        o_ir_valid,
    output logic                        o_stall_req
);

    lc3b_types::lc3b_word pc;
    lc3b_types::lc3b_word pc_plus2;
    lc3b_types::lc3b_word pc_next;
    logic                 req_q;

    assign pc_plus2 = pc + 16'd2;

    always_comb begin
        case (i_pc_mux_sel)
            lc3b_types::PC_ALU: pc_next = i_alu;
            lc3b_types::PC_PCN: pc_next = i_pcn;
            lc3b_types::PC_MDR: pc_next = i_mdr;
            default:            pc_next = pc_plus2;
        endcase
    end

    // Fetch is always wanted once out of reset.
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            req_q      <= 1'b0;
            pc         <= `LC3B_RESET_PC;
            o_ir_valid <= 1'b0;
        end else begin
            req_q      <= 1'b1;
            o_ir_valid <= i_ack;
            if (i_ack && !i_stall) begin
                pc <= pc_next;
            end
        end
    end

    // Instruction and its PC+2 travel together.
    always_ff @(posedge clk) begin
        if (i_ack) begin
            o_ir       <= i_rdata[{pc[3:1], 4'b0000} +: 16];
            o_pc_plus2 <= pc_plus2;
        end
    end

    assign o_req       = req_q;
    assign o_addr      = pc[15:4];
    assign o_stall_req = o_req & ~i_ack;

endmodule : stage_if

//--- hw/mem_access/stage_mem_access.sv
`timescale 1ns/10ps

module stage_mem_access (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  lc3b_types::lc3b_mem_op      i_mem_op,
    input  lc3b_types::lc3b_word        i_addr,
    input  lc3b_types::lc3b_word        i_wdata,
    input  logic                        i_ack,
    input  lc3b_bus_pkg::lc3b_line      i_rdata,

    output logic                        o_req,
    output lc3b_bus_pkg::lc3b_line_addr o_addr,
    output logic                        o_we,
    output lc3b_bus_pkg::lc3b_byte_sel  o_sel,
    output lc3b_bus_pkg::lc3b_line      o_wline,
    output lc3b_types::lc3b_word        o_rdata,
    output logic                        o_done,
    output logic                        o_stall_req
);

    logic                 pending;
    logic                 is_byte;
    lc3b_types::lc3b_word load_word;
    lc3b_types::lc3b_byte load_byte;

    assign is_byte = (i_mem_op == lc3b_types::MEM_LDB) || (i_mem_op == lc3b_types::MEM_STB);

    assign o_req  = (i_mem_op != lc3b_types::MEM_NONE) && !pending;
    assign o_addr = i_addr[15:4];
    assign o_we   = (i_mem_op == lc3b_types::MEM_STR) || (i_mem_op == lc3b_types::MEM_STB);

    // Replicate the store data; the lane select picks the target.
    always_comb begin
        if (is_byte) begin
            o_sel   = 16'h0001 << i_addr[3:0];
            o_wline = {16{i_wdata[7:0]}};
        end else begin
            o_sel   = 16'h0003 << {i_addr[3:1], 1'b0};
            o_wline = {8{i_wdata}};
        end
    end

    assign load_word = i_rdata[{i_addr[3:1], 4'b0000} +: 16];
    assign load_byte = i_rdata[{i_addr[3:0], 3'b000} +: 8];

    // Completion flag, also blocks re-issue during done.
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            pending <= 1'b0;
        end else begin
            pending <= i_ack;
        end
    end

    always_ff @(posedge clk) begin
        if (i_ack) begin
            if (is_byte) begin
                o_rdata <= {{8{load_byte[7]}}, load_byte};
            end else begin
                o_rdata <= load_word;
            end
        end
    end

    assign o_done      = pending;
    assign o_stall_req = o_req & ~i_ack;

endmodule : stage_mem_access

//--- hw/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_if_req,
    input  lc3b_bus_pkg::lc3b_line_addr i_if_addr,
    input  logic                        i_dp_req,
    input  lc3b_bus_pkg::lc3b_line_addr i_dp_addr,
    input  logic                        i_dp_we,
    input  lc3b_bus_pkg::lc3b_byte_sel  i_dp_sel,
    input  lc3b_bus_pkg::lc3b_line      i_dp_wline,
    input  logic                        i_mem_ack,

    output logic                        o_if_ack,
    output logic                        o_dp_ack,
    output logic                        o_mem_req,
    output lc3b_bus_pkg::lc3b_line_addr o_mem_addr,
    output logic                        o_mem_we,
    output lc3b_bus_pkg::lc3b_byte_sel  o_mem_sel,
    output lc3b_bus_pkg::lc3b_line      o_mem_wline
);

    lc3b_bus_pkg::lc3b_arb_state state;
    lc3b_bus_pkg::lc3b_arb_state state_next;
    logic                        data_granted;

    // Data port wins a tie.
    always_comb begin
        state_next = state;
        case (state)
            lc3b_bus_pkg::ARB_IDLE: begin
                if (i_dp_req) begin
                    state_next = lc3b_bus_pkg::ARB_DATA;
                end else if (i_if_req) begin
                    state_next = lc3b_bus_pkg::ARB_FETCH;
                end
            end
            default: begin
                if (i_mem_ack) begin
                    state_next = lc3b_bus_pkg::ARB_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state <= lc3b_bus_pkg::ARB_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign data_granted = (state == lc3b_bus_pkg::ARB_DATA);

    assign o_mem_req   = (state != lc3b_bus_pkg::ARB_IDLE);
    assign o_mem_addr  = data_granted ? i_dp_addr : i_if_addr;
    assign o_mem_we    = data_granted & i_dp_we;
    assign o_mem_sel   = data_granted ? i_dp_sel : '0;
    assign o_mem_wline = i_dp_wline;

    assign o_if_ack = (state == lc3b_bus_pkg::ARB_FETCH) & i_mem_ack;
    assign o_dp_ack = data_granted & i_mem_ack;

endmodule : mem_arbiter

//--- hw/line_memory.sv
`timescale 1ns/10ps
`include "lc3b_consts.svh"

module line_memory (
    input  logic                        clk,
    input  logic                        i_rst_n,
    input  logic                        i_req,
    input  lc3b_bus_pkg::lc3b_line_addr i_addr,
    input  logic                        i_we,
    input  lc3b_bus_pkg::lc3b_byte_sel  i_sel,
    input  lc3b_bus_pkg::lc3b_line      i_wline,

    output logic                        o_ack,
    output lc3b_bus_pkg::lc3b_line      o_rline
);

    localparam int CNT_W = $clog2(`LC3B_MEM_LATENCY + 1);

    lc3b_bus_pkg::lc3b_line mem [`LC3B_MEM_DEPTH];
    logic [CNT_W-1:0]       cnt;
    logic [`LC3B_MEM_LINE_BITS-1:0] idx;

    initial begin
        for (int i = 0; i < `LC3B_MEM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    assign idx = i_addr[`LC3B_MEM_LINE_BITS-1:0];

    // Counts held-request cycles up to the fixed latency.
    always_ff @(posedge clk) begin
        if (!i_rst_n || !i_req || o_ack) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign o_ack   = i_req && (cnt == CNT_W'(`LC3B_MEM_LATENCY));
    assign o_rline = mem[idx];

    // Only enabled lanes change.
    always_ff @(posedge clk) begin
        if (o_ack && i_we) begin
            for (int b = 0; b < 16; b++) begin
                if (i_sel[b]) begin
                    mem[idx][b*8 +: 8] <= i_wline[b*8 +: 8];
                end
            end
        end
    end

endmodule : line_memory

//--- hw/lc3b_mem_subsystem.sv
`timescale 1ns/10ps

module lc3b_mem_subsystem (
    input  logic                       clk,
    input  logic                       i_rst_n,
    input  logic                       i_stall,
    input  lc3b_types::lc3b_pc_mux_sel i_pc_mux_sel,
    input  lc3b_types::lc3b_word       i_alu,
    input  lc3b_types::lc3b_word       i_pcn,
    input  lc3b_types::lc3b_word       i_mdr,
    input  lc3b_types::lc3b_mem_op     i_mem_op,
    input  lc3b_types::lc3b_word       i_mem_addr,
    input  lc3b_types::lc3b_word       i_mem_wdata,

    output lc3b_types::lc3b_word       o_ir,
    output lc3b_types::lc3b_word       o_pc_plus2,
    output logic                       o_ir_valid,
    output lc3b_types::lc3b_word       o_mem_rdata,
    output logic                       o_mem_done,
    output logic                       o_stall
);

    logic                        if_req;
    logic                        if_ack;
    logic                        if_stall_req;
    lc3b_bus_pkg::lc3b_line_addr if_addr;

    logic                        dp_req;
    logic                        dp_ack;
    logic                        dp_we;
    logic                        dp_stall_req;
    lc3b_bus_pkg::lc3b_line_addr dp_addr;
    lc3b_bus_pkg::lc3b_byte_sel  dp_sel;
    lc3b_bus_pkg::lc3b_line      dp_wline;

    logic                        mem_req;
    logic                        mem_ack;
    logic                        mem_we;
    lc3b_bus_pkg::lc3b_line_addr mem_addr;
    lc3b_bus_pkg::lc3b_byte_sel  mem_sel;
    lc3b_bus_pkg::lc3b_line      mem_wline;
    lc3b_bus_pkg::lc3b_line      mem_rline;

    stage_if u_stage_if (
        .clk, .i_rst_n, .i_stall, .i_pc_mux_sel, .i_alu, .i_pcn, .i_mdr,
        .i_ack(if_ack), .i_rdata(mem_rline),
        .o_req(if_req), .o_addr(if_addr), .o_ir, .o_pc_plus2, .o_ir_valid,
        .o_stall_req(if_stall_req)
    );

    stage_mem_access u_stage_mem_access (
        .clk, .i_rst_n, .i_mem_op, .i_addr(i_mem_addr), .i_wdata(i_mem_wdata),
        .i_ack(dp_ack), .i_rdata(mem_rline),
        .o_req(dp_req), .o_addr(dp_addr), .o_we(dp_we), .o_sel(dp_sel),
        .o_wline(dp_wline), .o_rdata(o_mem_rdata), .o_done(o_mem_done),
        .o_stall_req(dp_stall_req)
    );

    mem_arbiter u_mem_arbiter (
        .clk, .i_rst_n, .i_if_req(if_req), .i_if_addr(if_addr),
        .i_dp_req(dp_req), .i_dp_addr(dp_addr), .i_dp_we(dp_we),
        .i_dp_sel(dp_sel), .i_dp_wline(dp_wline), .i_mem_ack(mem_ack),
        .o_if_ack(if_ack), .o_dp_ack(dp_ack), .o_mem_req(mem_req),
        .o_mem_addr(mem_addr), .o_mem_we(mem_we), .o_mem_sel(mem_sel),
        .o_mem_wline(mem_wline)
    );

    line_memory u_line_memory (
        .clk, .i_rst_n, .i_req(mem_req), .i_addr(mem_addr), .i_we(mem_we),
        .i_sel(mem_sel), .i_wline(mem_wline),
        .o_ack(mem_ack), .o_rline(mem_rline)
    );

    // One pipeline stall from both stages.
    assign o_stall = if_stall_req | dp_stall_req;

endmodule : lc3b_mem_subsystem

//--- test/tb_lc3b_mem_subsystem.sv
`timescale 1ns/10ps
`include "lc3b_consts.svh"

module tb_lc3b_mem_subsystem;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int MAX_TESTS    = 64;

    logic                       clk;
    logic                       i_rst_n;
    logic                       i_stall;
    lc3b_types::lc3b_pc_mux_sel i_pc_mux_sel;
    lc3b_types::lc3b_word       i_alu;
    lc3b_types::lc3b_word       i_pcn;
    lc3b_types::lc3b_word       i_mdr;
    lc3b_types::lc3b_mem_op     i_mem_op;
    lc3b_types::lc3b_word       i_mem_addr;
    lc3b_types::lc3b_word       i_mem_wdata;
    lc3b_types::lc3b_word       o_ir;
    lc3b_types::lc3b_word       o_pc_plus2;
    logic                       o_ir_valid;
    lc3b_types::lc3b_word       o_mem_rdata;
    logic                       o_mem_done;
    logic                       o_stall;

    int                   t_kind [MAX_TESTS];
    int                   t_code [MAX_TESTS];
    lc3b_types::lc3b_word t_addr [MAX_TESTS];
    lc3b_types::lc3b_word t_wdata [MAX_TESTS];
    lc3b_types::lc3b_word t_exp [MAX_TESTS];
    lc3b_types::lc3b_word t_pc2 [MAX_TESTS];
    int                   n_tests;
    logic                 loaded;
    lc3b_types::lc3b_word shadow_pc;

    lc3b_mem_subsystem u_lc3b_mem_subsystem (
        .clk, .i_rst_n, .i_stall, .i_pc_mux_sel, .i_alu, .i_pcn, .i_mdr,
        .i_mem_op, .i_mem_addr, .i_mem_wdata,
        .o_ir, .o_pc_plus2, .o_ir_valid, .o_mem_rdata, .o_mem_done, .o_stall
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_word(input string name, input lc3b_types::lc3b_word expected,
                              input lc3b_types::lc3b_word actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            abort_run("word mismatch");
        end
    endtask

    task automatic check_op(input string name, input lc3b_types::lc3b_mem_op expected,
                            input lc3b_types::lc3b_mem_op actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %s, actual %s", name, expected.name(), actual.name());
            abort_run("operation mismatch");
        end
    endtask

    // Kind of access seen at the memory bus.
    function automatic lc3b_types::lc3b_mem_op op_from_bus(
        input logic                       we,
        input lc3b_bus_pkg::lc3b_byte_sel sel
    );
        if ($countones(sel) == 1) begin
            return we ? lc3b_types::MEM_STB : lc3b_types::MEM_LDB;
        end
        if ($countones(sel) == 2) begin
            return we ? lc3b_types::MEM_STR : lc3b_types::MEM_LDR;
        end
        return lc3b_types::MEM_NONE;
    endfunction

    task automatic load_tests();
        int          fd;
        int          code;
        string       line;
        int unsigned f_kind, f_code, f_addr, f_wdata, f_exp, f_pc2;
        fd = $fopen("test/lc3b_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the test data file");
        end
        while (!$feof(fd) && n_tests < MAX_TESTS) begin
            code = $fgets(line, fd);
            if (code != 0 && line.len() > 1 && line.substr(0, 1) != "//") begin
                if ($sscanf(line, "%h %h %h %h %h %h", f_kind, f_code, f_addr, f_wdata,
                            f_exp, f_pc2) == 6) begin
                    t_kind[n_tests]  = f_kind;
                    t_code[n_tests]  = f_code;
                    t_addr[n_tests]  = f_addr[15:0];
                    t_wdata[n_tests] = f_wdata[15:0];
                    t_exp[n_tests]   = f_exp[15:0];
                    t_pc2[n_tests]   = f_pc2[15:0];
                    n_tests++;
                end
            end
        end
        $fclose(fd);
        if (n_tests == 0) begin
            abort_run("the test data file holds no tests");
        end
    endtask

    // Holds the operation until done; PC is frozen by the stall meanwhile.
    task automatic run_data_op(input int idx);
        string                  name;
        lc3b_types::lc3b_mem_op op;
        lc3b_types::lc3b_mem_op seen_op;
        logic                   done;
        name    = $sformatf("test %0d data op", idx);
        op      = lc3b_types::lc3b_mem_op'(t_code[idx][2:0]);
        seen_op = lc3b_types::MEM_NONE;
        done    = 1'b0;
        @(posedge clk);
        i_stall     <= 1'b1;
        i_mem_op    <= op;
        i_mem_addr  <= t_addr[idx];
        i_mem_wdata <= t_wdata[idx];
        while (!done) begin
            @(negedge clk);
            if (u_lc3b_mem_subsystem.dp_ack) begin
                seen_op = op_from_bus(u_lc3b_mem_subsystem.mem_we,
                                      u_lc3b_mem_subsystem.mem_sel);
            end
            if (o_ir_valid) begin
                check_word({name, " pc+2 under stall"}, shadow_pc + 16'd2, o_pc_plus2);
            end
            if (o_mem_done) begin
                done = 1'b1;
            end else if (!o_stall) begin
                abort_run({"o_stall low while a data access was outstanding in ", name});
            end
        end
        check_op(name, op, seen_op);
        if (t_kind[idx] == 1) begin
            check_word({name, " load data"}, t_exp[idx], o_mem_rdata);
        end
    endtask

    task automatic run_fetch(input int idx, input bit hold);
        string                      name;
        lc3b_types::lc3b_pc_mux_sel sel;
        logic                       got;
        name = $sformatf("test %0d fetch", idx);
        sel  = lc3b_types::lc3b_pc_mux_sel'(t_code[idx][1:0]);
        got  = 1'b0;
        @(posedge clk);
        i_stall      <= hold;
        i_mem_op     <= lc3b_types::MEM_NONE;
        i_pc_mux_sel <= sel;
        i_alu        <= lc3b_types::lc3b_word'($urandom);
        i_pcn        <= lc3b_types::lc3b_word'($urandom);
        i_mdr        <= lc3b_types::lc3b_word'($urandom);
        case (sel)
            lc3b_types::PC_ALU: i_alu <= t_addr[idx];
            lc3b_types::PC_PCN: i_pcn <= t_addr[idx];
            lc3b_types::PC_MDR: i_mdr <= t_addr[idx];
            default: ;
        endcase
        // A valid here answers an acknowledge that saw the old inputs.
        @(negedge clk);
        while (!got) begin
            @(negedge clk);
            got = o_ir_valid;
        end
        check_word({name, " instruction"}, t_exp[idx], o_ir);
        check_word({name, " pc+2"}, t_pc2[idx], o_pc_plus2);
        if (!hold) begin
            if (sel == lc3b_types::PC_PLUS2) begin
                shadow_pc = shadow_pc + 16'd2;
            end else begin
                shadow_pc = t_addr[idx];
            end
        end
    endtask

    initial begin
        wait (loaded);
        #(n_tests * (`LC3B_MEM_LATENCY + 8) * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);
        $display("run timed out waiting for an acknowledge");
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(32'h2ea3));
        i_rst_n      = 1'b0;
        i_stall      = 1'b1;
        i_pc_mux_sel = lc3b_types::PC_PLUS2;
        i_alu        = '0;
        i_pcn        = '0;
        i_mdr        = '0;
        i_mem_op     = lc3b_types::MEM_NONE;
        i_mem_addr   = '0;
        i_mem_wdata  = '0;
        n_tests      = 0;
        loaded       = 1'b0;
        shadow_pc    = `LC3B_RESET_PC;
        load_tests();
        loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        i_rst_n <= 1'b1;
        for (int i = 0; i < n_tests; i++) begin
            if (t_kind[i] < 2) begin
                run_data_op(i);
            end else begin
                run_fetch(i, t_kind[i] == 3);
            end
        end
        $display("all tests passed");
        $finish;
    end

endmodule : tb_lc3b_mem_subsystem

//--- list.f
+incdir+common
common/lc3b_types.sv
common/lc3b_bus_pkg.sv
hw/fetch/stage_if.sv
hw/mem_access/stage_mem_access.sv
hw/mem_arbiter.sv
hw/line_memory.sv
hw/lc3b_mem_subsystem.sv
test/tb_lc3b_mem_subsystem.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_lc3b_mem_subsystem
FILELIST  = list.f
OBJ_DIR   = obj_dir
PASS_MSG  = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- test/lc3b_testdata.txt
// kind: 0 store, 1 load, 2 fetch, 3 fetch under stall; code: mem op or PC select
// columns: kind code addr_or_target wdata expected_word expected_pc_plus2
0 2 0000 a000 0000 0000
0 2 0002 a002 0000 0000
0 2 000e a00e 0000 0000
0 2 0010 a010 0000 0000
0 2 0040 1111 0000 0000
0 2 0044 3333 0000 0000
0 2 0042 2222 0000 0000
1 1 0040 0000 1111 0000
1 1 0042 0000 2222 0000
1 1 0045 0000 3333 0000
0 4 0043 0085 0000 0000
1 1 0042 0000 8522 0000
1 3 0043 0000 ff85 0000
1 3 0042 0000 0022 0000
0 4 0040 12f0 0000 0000
1 3 0040 0000 fff0 0000
2 0 0000 0000 a000 0002
2 0 0000 0000 a002 0004
2 1 000e 0000 0000 0006
2 0 0000 0000 a00e 0010
2 2 0040 0000 a010 0012
2 3 0044 0000 11f0 0042
3 0 0000 0000 3333 0046
2 0 0000 0000 3333 0046
0 2 0046 7777 0000 0000
1 1 0042 0000 8522 0000
2 0 0000 0000 7777 0048
